//--- vlog.f
design/accel_pkg.sv
design/int8_mul_unit.sv
design/accel_cr_mem.sv
design/accel_top.sv
bench/accel_tb.sv

//--- run.sh
#!/bin/sh
# build the accelerator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module accel_tb -o accel_sim

# the simulator exits non-zero on $fatal, the search below decides the result
out=$(./obj_dir/accel_sim 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "TEST PASS"

//--- bench/accel_tb.sv
// directed testbench for the int8 multiplier farm, drives the core register bus of accel_top
`default_nettype none

module accel_tb;

    // polls of a done register before giving up on a unit
    localparam int done_timeout = 40;

    logic        clk;
    logic        arst_n;
    logic [31:0] data;
    logic [31:0] address;
    logic        wren;
    logic        rden;
    logic [31:0] q;

    // products the DUT should hold, filled as tests complete
    logic [31:0] exp_res [8];

    accel_top i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .data    (data),
        .address (address),
        .wren    (wren),
        .rden    (rden),
        .q       (q)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // address map and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] operand_addr(input int unit);
        return accel_pkg::cr_core2mul_base + 32'(4 * unit);
    endfunction

    function automatic logic [31:0] result_addr(input int unit);
        return accel_pkg::cr_mul2core_base + 32'(8 * unit);
    endfunction

    function automatic logic [31:0] done_flag_addr(input int unit);
        return accel_pkg::cr_mul2core_base + 32'(8 * unit + 4);
    endfunction

    // signed product, low 16 bits, zero extended to the bus
    function automatic logic [31:0] exp_product(input int a, input int b);
        int p;
        p = a * b;
        return {16'h0000, p[15:0]};
    endfunction

    // ------------------------------------------------------------
    // failure reporting and checks
    // ------------------------------------------------------------
    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
            fail_run();
        end
    endtask

    // ------------------------------------------------------------
    // bus tasks, entered and left on a falling edge
    // ------------------------------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        address = addr;
        data    = wdata;
        wren    = 1'b1;
        @(negedge clk);
        wren = 1'b0;
    endtask

    // q is loaded on the rising edge, sampled on the falling edge after it
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] val);
        address = addr;
        rden    = 1'b1;
        @(negedge clk);
        rden = 1'b0;
        val  = q;
    endtask

    task automatic mul_write(input int unit, input int a, input int b);
        bus_write(operand_addr(unit), {16'h0000, 8'(a), 8'(b)});
    endtask

    task automatic wait_done(input int unit);
        logic [31:0] val;
        int          polls;
        // start flop plus status sampling, so a fresh start shows done low
        idle_cycles(2);
        polls = 0;
        val   = '0;
        while (val[0] !== 1'b1) begin
            if (polls == done_timeout) begin
                $display("unit %0d did not report done within %0d polls", unit, done_timeout);
                fail_run();
            end
            bus_read(done_flag_addr(unit), val);
            polls++;
        end
        check($sformatf("done[%0d]", unit), val, 32'd1);
    endtask

    // multiply, wait, and compare the product
    task automatic run_and_check(input int unit, input int a, input int b);
        logic [31:0] val;
        mul_write(unit, a, b);
        wait_done(unit);
        bus_read(result_addr(unit), val);
        exp_res[unit] = exp_product(a, b);
        check($sformatf("result[%0d]", unit), val, exp_res[unit]);
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic reset_test();
        logic [31:0] val;
        check("q after reset", q, 32'd0);
        for (int i = 0; i < 8; i++) begin
            bus_read(done_flag_addr(i), val);
            check($sformatf("done[%0d] after reset", i), val, 32'd0);
            bus_read(result_addr(i), val);
            check($sformatf("result[%0d] after reset", i), val, 32'd0);
        end
        $display("reset state checked");
    endtask

    task automatic single_mul_test();
        int dir_a [8] = '{7, -128, 0, 127, -1, -128, 100, -5};
        int dir_b [8] = '{-3, -128, 55, 127, 1, 127, -100, -9};
        for (int i = 0; i < 8; i++) begin
            run_and_check(i, dir_a[i], dir_b[i]);
        end
        $display("single multiplies checked");
    endtask

    task automatic concurrent_test();
        logic [31:0] r;
        logic [31:0] val;
        int          a [8];
        int          b [8];
        // all writes on consecutive cycles, every unit busy at once
        for (int i = 0; i < 8; i++) begin
            r    = $urandom();
            a[i] = int'($signed(r[15:8]));
            b[i] = int'($signed(r[7:0]));
            mul_write(i, a[i], b[i]);
        end
        for (int i = 0; i < 8; i++) begin
            wait_done(i);
            bus_read(result_addr(i), val);
            exp_res[i] = exp_product(a[i], b[i]);
            check($sformatf("farm result[%0d]", i), val, exp_res[i]);
        end
        $display("concurrent farm checked");
    endtask

    task automatic restart_test();
        logic [31:0] val;
        mul_write(2, 33, -77);
        mul_write(2, -19, 101);
        wait_done(2);
        bus_read(result_addr(2), val);
        exp_res[2] = exp_product(-19, 101);
        check("result[2] after restart", val, exp_res[2]);

        mul_write(2, -128, 1);
        // done is cleared two edges after the accepting edge
        idle_cycles(2);
        bus_read(done_flag_addr(2), val);
        check("done[2] after new write", val, 32'd0);
        wait_done(2);
        bus_read(result_addr(2), val);
        exp_res[2] = exp_product(-128, 1);
        check("result[2] after new write", val, exp_res[2]);
        $display("restart checked");
    endtask

    task automatic miss_test();
        logic [31:0] prev;
        logic [31:0] val;
        // unit 2 holds a known nonzero product
        bus_read(result_addr(2), prev);
        check("result[2]", prev, exp_res[2]);

        bus_read(32'h0000_0100, val);
        check("q after unmapped read", val, prev);
        bus_read(operand_addr(3), val);
        check("q after operand read", val, prev);

        // mapped address but rden low
        address = done_flag_addr(0);
        idle_cycles(1);
        check("q with rden low", q, prev);

        // writes outside the operand registers
        bus_write(32'h0000_0020, 32'h0000_7f7f);
        bus_write(done_flag_addr(5), 32'h0000_0000);
        bus_write(result_addr(6), 32'h0000_1234);
        idle_cycles(2);
        for (int i = 0; i < 8; i++) begin
            bus_read(done_flag_addr(i), val);
            check($sformatf("done[%0d] after unmapped writes", i), val, 32'd1);
            bus_read(result_addr(i), val);
            check($sformatf("result[%0d] after unmapped writes", i), val, exp_res[i]);
        end
        $display("read and write misses checked");
    endtask

    task automatic pipelined_read_test();
        // one read issued every cycle, each result seen one cycle later
        address = result_addr(0);
        rden    = 1'b1;
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk);
            check($sformatf("pipelined result[%0d]", i - 1), q, exp_res[i - 1]);
            if (i < 8) begin
                address = result_addr(i);
            end else begin
                rden = 1'b0;
            end
        end
        $display("pipelined reads checked");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin : main
        arst_n  = 1'b0;
        wren    = 1'b0;
        rden    = 1'b0;
        data    = '0;
        address = '0;
        for (int i = 0; i < 8; i++) begin
            exp_res[i] = '0;
        end
        void'($urandom(48));

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        reset_test();
        single_mul_test();
        concurrent_test();
        restart_test();
        miss_test();
        pipelined_read_test();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/accel_top.sv
// accelerator top level, register block on the core bus driving eight int8 multiplier units
`default_nettype none

module accel_top (
    input  var logic                            clk,
    input  var logic                            arst_n,

    // core register bus
    input  var logic [accel_pkg::cr_data_w-1:0] data,
    input  var logic [accel_pkg::cr_addr_w-1:0] address,
    input  var logic                            wren,
    input  var logic                            rden,
    output logic [accel_pkg::cr_data_w-1:0]     q
);

    // ------------------------------------------------------------
    // farm connections
    // ------------------------------------------------------------
    // operands and start toward the units
    wire accel_pkg::t_farm_input  farm_input;
    // done and product back from the units
    wire accel_pkg::t_farm_output farm_output;

    accel_cr_mem i_cr_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .data        (data),
        .address     (address),
        .wren        (wren),
        .rden        (rden),
        .q           (q),
        .farm_output (farm_output),
        .farm_input  (farm_input)
    );

    // ------------------------------------------------------------
    // multiplier farm
    // ------------------------------------------------------------
    // one unit per element of the farm arrays
    for (genvar i = 0; i < accel_pkg::num_mul; i++) begin : g_mul
        int8_mul_unit i_mul (
            .clk      (clk),
            .arst_n   (arst_n),
            .core2mul (farm_input[i]),
            .mul2core (farm_output[i])
        );
    end

endmodule

`default_nettype wire

//--- design/accel_cr_mem.sv
// control register block between the core bus and the multiplier farm, decodes reads and writes
`default_nettype none

module accel_cr_mem (
    input  var logic                           clk,
    input  var logic                           arst_n,

    // core register bus
    input  var logic [accel_pkg::cr_data_w-1:0] data,
    input  var logic [accel_pkg::cr_addr_w-1:0] address,
    input  var logic                           wren,
    input  var logic                           rden,
    output logic [accel_pkg::cr_data_w-1:0]    q,

    // multiplier farm
    input  var accel_pkg::t_farm_output        farm_output,
    output accel_pkg::t_farm_input             farm_input
);

    // operand pair per unit, as written by the core
    logic [accel_pkg::num_mul-1:0][accel_pkg::cr_opnd_w-1:0] opnd_q;

    // one start strobe per unit
    logic [accel_pkg::num_mul-1:0] start_q;
    logic [accel_pkg::num_mul-1:0] wr_hit;

    // done and result of every unit, one cycle behind the farm
    accel_pkg::t_farm_output status_q;

    logic [accel_pkg::cr_data_w-1:0] q_next;

    // ------------------------------------------------------------
    // write side
    // ------------------------------------------------------------
    always_comb begin : write_decode
        for (int i = 0; i < accel_pkg::num_mul; i++) begin
            wr_hit[i] = wren && (address == accel_pkg::opnd_addr(i));
        end
    end

    // the write edge also fires the unit's start
    always_ff @(posedge clk or negedge arst_n) begin : operand_regs
        if (!arst_n) begin
            opnd_q  <= '0;
            start_q <= '0;
        end else begin
            start_q <= wr_hit;
            for (int i = 0; i < accel_pkg::num_mul; i++) begin
                if (wr_hit[i]) begin
                    opnd_q[i] <= data[accel_pkg::cr_opnd_w-1:0];
                end
            end
        end
    end

    // upper byte is the multiplicand, lower byte the multiplier
    always_comb begin : farm_drive
        for (int i = 0; i < accel_pkg::num_mul; i++) begin
            farm_input[i].start        = start_q[i];
            farm_input[i].multiplicand = opnd_q[i][accel_pkg::cr_opnd_w-1:accel_pkg::mul_op_w];
            farm_input[i].multiplier   = opnd_q[i][accel_pkg::mul_op_w-1:0];
        end
    end

    // ------------------------------------------------------------
    // farm status sampling
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin : status_regs
        if (!arst_n) begin
            status_q <= '0;
        end else begin
            status_q <= farm_output;
        end
    end

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------
    // misses and idle cycles keep the last value on q
    always_comb begin : read_mux
        q_next = q;
        if (rden) begin
            for (int i = 0; i < accel_pkg::num_mul; i++) begin
                if (address == accel_pkg::res_addr(i)) begin
                    q_next = {{(accel_pkg::cr_data_w - accel_pkg::mul_res_w){1'b0}},
                              status_q[i].result};
                end else if (address == accel_pkg::done_addr(i)) begin
                    q_next = {{(accel_pkg::cr_data_w - 1){1'b0}}, status_q[i].done};
                end
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk or negedge arst_n) begin : read_reg
        if (!arst_n) begin
            q <= '0;
        end else begin
            q <= q_next;
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // idle bus cycles must not disturb the read data
    a_q_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        !rden |=> $stable(q)
    );

    // a single bus write can start only one unit
    a_one_start: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(start_q)
    );

endmodule

`default_nettype wire

//--- design/int8_mul_unit.sv
// iterative signed 8x8 shift-add multiplier, started by a strobe and reporting done with the product
`default_nettype none

module int8_mul_unit (
    input  var logic                  clk,
    input  var logic                  arst_n,
    input  var accel_pkg::t_core2mul  core2mul,
    output accel_pkg::t_mul2core      mul2core
);

    accel_pkg::t_mul_state state_q;

    logic [accel_pkg::mul_cnt_w-1:0] iter_q;
    logic                            done_q;
    logic [accel_pkg::mul_res_w-1:0] result_q;

    // datapath, loaded on start
    logic [accel_pkg::mul_res_w-1:0] mcand_q;
    logic [accel_pkg::mul_op_w-1:0]  mplier_q;
    logic [accel_pkg::mul_res_w-1:0] acc_q;

    logic                            last_step;
    logic [accel_pkg::mul_res_w-1:0] pp;
    logic [accel_pkg::mul_res_w-1:0] acc_next;

    // ------------------------------------------------------------
    // shift-add step
    // ------------------------------------------------------------
    // the multiplier sign bit carries weight -2^7, so the last
    // partial product is subtracted instead of added
    always_comb begin : step
        last_step = (iter_q == accel_pkg::mul_last_iter);
        pp        = mplier_q[0] ? mcand_q : '0;
        acc_next  = last_step ? (acc_q - pp) : (acc_q + pp);
    end

    always_ff @(posedge clk) begin : datapath
        if (core2mul.start) begin
            // sign extend the multiplicand to product width
            mcand_q  <= {{(accel_pkg::mul_res_w - accel_pkg::mul_op_w)
                          {core2mul.multiplicand[accel_pkg::mul_op_w-1]}},
                         core2mul.multiplicand};
            mplier_q <= core2mul.multiplier;
            acc_q    <= '0;
        end else if (state_q == accel_pkg::mul_busy) begin
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            acc_q    <= acc_next;
        end
    end

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    // a start while busy simply restarts with the new operands
    always_ff @(posedge clk or negedge arst_n) begin : control
        if (!arst_n) begin
            state_q  <= accel_pkg::mul_idle;
            iter_q   <= '0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else if (core2mul.start) begin
            state_q <= accel_pkg::mul_busy;
            iter_q  <= '0;
            done_q  <= 1'b0;
        end else if (state_q == accel_pkg::mul_busy) begin
            if (last_step) begin
                state_q  <= accel_pkg::mul_idle;
                iter_q   <= '0;
                done_q   <= 1'b1;
                result_q <= acc_next;
            end else begin
                iter_q <= iter_q + 1'b1;
            end
        end
    end

    // done stays up until the next start
    assign mul2core = '{done: done_q, result: result_q};

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_no_done_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state_q == accel_pkg::mul_busy) |-> !done_q
    );

    // counter must be back at zero for the next start
    a_iter_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state_q == accel_pkg::mul_idle) |-> (iter_q == '0)
    );

endmodule

`default_nettype wire

//--- design/accel_pkg.sv
// shared address map, widths, unit state and farm structs for the int8 accelerator
`default_nettype none

package accel_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------
    localparam int num_mul   = 8;
    localparam int cr_addr_w = 32;
    localparam int cr_data_w = 32;

    // one operand, the packed operand pair and the product
    localparam int mul_op_w  = 8;
    localparam int cr_opnd_w = 2 * mul_op_w;
    localparam int mul_res_w = 2 * mul_op_w;

    // one shift-add step per multiplier bit
    localparam int mul_cnt_w = $clog2(mul_op_w);
    localparam logic [mul_cnt_w-1:0] mul_last_iter = mul_cnt_w'(mul_op_w - 1);

    // ------------------------------------------------------------
    // core address map
    // ------------------------------------------------------------
    // operand pair {multiplicand, multiplier}, one word per unit
    localparam logic [cr_addr_w-1:0] cr_core2mul_base   = 32'h0000_0000;
    localparam int                   cr_core2mul_stride = 4;

    // result word then done word, two words per unit
    localparam logic [cr_addr_w-1:0] cr_mul2core_base   = 32'h0000_0040;
    localparam int                   cr_mul2core_stride = 8;
    localparam int                   cr_done_offset     = 4;

    function automatic logic [cr_addr_w-1:0] opnd_addr(input int idx);
        return cr_core2mul_base + cr_addr_w'(idx * cr_core2mul_stride);
    endfunction

    function automatic logic [cr_addr_w-1:0] res_addr(input int idx);
        return cr_mul2core_base + cr_addr_w'(idx * cr_mul2core_stride);
    endfunction

    function automatic logic [cr_addr_w-1:0] done_addr(input int idx);
        return res_addr(idx) + cr_addr_w'(cr_done_offset);
    endfunction

    // ------------------------------------------------------------
    // unit state and farm side types
    // ------------------------------------------------------------
    typedef enum logic {
        mul_idle,
        mul_busy
    } t_mul_state;

    // start is a single cycle strobe, operands stay valid after it
    typedef struct packed {
        logic                       start;
        logic signed [mul_op_w-1:0] multiplicand;
        logic signed [mul_op_w-1:0] multiplier;
    } t_core2mul;

    typedef struct packed {
        logic                 done;
        logic [mul_res_w-1:0] result;
    } t_mul2core;

    typedef t_core2mul [num_mul-1:0] t_farm_input;
    typedef t_mul2core [num_mul-1:0] t_farm_output;

endpackage

`default_nettype wire
